//--- hw/serial_link_pkg.sv
/*
 * Shared widths, register map and types for the serial link.
 * Modules import this package wherever they use its contents.
 */
package serial_link_pkg;

  // Link geometry
  localparam int NumLanes     = 8;
  localparam int PayloadBits  = 32;
  localparam int FlitSplits   = PayloadBits / NumLanes;
  localparam int ClkDivBits   = 8;
  localparam int MinClkDiv    = 2;
  localparam int RawFifoDepth = 8;

  // Register bus geometry
  localparam int RegAddrBits = 3;
  localparam int RegDataBits = 32;

  typedef logic [NumLanes-1:0]    lane_data_t;
  typedef logic [PayloadBits-1:0] payload_t;
  typedef logic [ClkDivBits-1:0]  clk_div_t;
  typedef logic [3:0]             raw_level_t;
  typedef logic [RegAddrBits-1:0] reg_addr_t;
  typedef logic [RegDataBits-1:0] reg_data_t;

  // Register map
  localparam reg_addr_t RegCtrl   = 3'd0;
  localparam reg_addr_t RegClkDiv = 3'd1;
  localparam reg_addr_t RegRawOut = 3'd2;
  localparam reg_addr_t RegRawIn  = 3'd3;
  localparam reg_addr_t RegStatus = 3'd4;

  // Clock enabled and link out of reset, no isolation, data mode
  localparam reg_data_t CtrlReset   = 32'h0000_0003;
  localparam clk_div_t  ClkDivReset = 8'd4;

  typedef enum logic [1:0] {
    IDLE,
    LOW,
    HIGH
  } tx_state_e;

endpackage

//--- hw/serial_link_fifo.sv
/*
 * Small synchronous FIFO for raw-mode flits.
 * The head entry is always visible on data_o.
 */
`timescale 1ns/1ps

module serial_link_fifo (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        push_i,
  input  serial_link_pkg::lane_data_t data_i,
  input  logic                        pop_i,
  output serial_link_pkg::lane_data_t data_o,
  output logic                        empty_o,
  output logic                        full_o,
  output serial_link_pkg::raw_level_t level_o
);
  import serial_link_pkg::*;

  lane_data_t                        mem_q [RawFifoDepth];
  logic [$clog2(RawFifoDepth)-1:0]   wr_ptr_q;
  logic [$clog2(RawFifoDepth)-1:0]   rd_ptr_q;
  raw_level_t                        level_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      level_q <= level_q + raw_level_t'(push_i) - raw_level_t'(pop_i);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign level_o = level_q;
  assign empty_o = (level_q == '0);
  assign full_o  = (level_q == raw_level_t'(RawFifoDepth));

  // Callers mask their strobes with the flags
  a_no_overflow : assert property (
    @(posedge clk_i) disable iff (reset_i) !(push_i && full_o)
  );
  a_no_underflow : assert property (
    @(posedge clk_i) disable iff (reset_i) !(pop_i && empty_o)
  );

endmodule

//--- hw/serial_link_reg_top.sv
/*
 * Configuration and status registers of the serial link.
 * Decodes the register bus and turns raw-mode accesses into FIFO strobes.
 */
`timescale 1ns/1ps

module serial_link_reg_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  serial_link_pkg::reg_addr_t  reg_addr_i,
  input  serial_link_pkg::reg_data_t  reg_wdata_i,
  input  logic                        reg_wr_i,
  input  logic                        reg_rd_i,
  output serial_link_pkg::reg_data_t  reg_rdata_o,
  input  logic [1:0]                  isolated_i,
  input  serial_link_pkg::raw_level_t raw_out_level_i,
  input  logic                        raw_out_full_i,
  input  serial_link_pkg::lane_data_t raw_in_data_i,
  input  logic                        raw_in_valid_i,
  output logic                        clk_ena_o,
  output logic                        reset_no,
  output logic [1:0]                  isolate_o,
  output logic                        raw_mode_en_o,
  output serial_link_pkg::clk_div_t   clk_div_o,
  output serial_link_pkg::lane_data_t raw_out_data_o,
  output logic                        raw_out_push_o,
  output logic                        raw_in_pop_o
);
  import serial_link_pkg::*;

  // Bit 0 clk_ena, bit 1 reset_n, bits 3:2 isolate, bit 4 raw mode
  logic [4:0] ctrl_q;
  clk_div_t   clk_div_q;

  //////////////////////////////
  // Writable registers
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q    <= CtrlReset[4:0];
      clk_div_q <= ClkDivReset;
    end else if (reg_wr_i) begin
      if (reg_addr_i == RegCtrl) begin
        ctrl_q <= reg_wdata_i[4:0];
      end
      if (reg_addr_i == RegClkDiv) begin
        clk_div_q <= reg_wdata_i[ClkDivBits-1:0];
      end
    end
  end

  assign clk_ena_o     = ctrl_q[0];
  assign reset_no      = ctrl_q[1];
  assign isolate_o     = ctrl_q[3:2];
  assign raw_mode_en_o = ctrl_q[4];
  assign clk_div_o     = clk_div_q;

  // Raw-mode FIFO strobes
  assign raw_out_data_o = reg_wdata_i[NumLanes-1:0];
  assign raw_out_push_o = reg_wr_i && (reg_addr_i == RegRawOut);
  assign raw_in_pop_o   = reg_rd_i && (reg_addr_i == RegRawIn) && raw_in_valid_i;

  //////////////////////////////
  // Read data mux
  //////////////////////////////

  always_comb begin
    reg_rdata_o = '0;
    if (reg_rd_i) begin
      case (reg_addr_i)
        RegCtrl:   reg_rdata_o = reg_data_t'(ctrl_q);
        RegClkDiv: reg_rdata_o = reg_data_t'(clk_div_q);
        RegRawOut: reg_rdata_o = reg_data_t'(raw_out_level_i);
        RegRawIn: begin
          // Empty FIFO reads as zero
          if (raw_in_valid_i) begin
            reg_rdata_o = reg_data_t'({1'b1, raw_in_data_i});
          end
        end
        RegStatus: reg_rdata_o = reg_data_t'({raw_out_full_i, isolated_i});
        default:   reg_rdata_o = '0;
      endcase
    end
  end

  // The bus master issues at most one access per cycle
  a_single_access : assert property (
    @(posedge clk_i) disable iff (reset_i) !(reg_wr_i && reg_rd_i)
  );

endmodule

//--- hw/serial_link_data_link.sv
/*
 * Data link layer. Splits payload words into lane-wide flits and reassembles
 * received flits into words, or routes flits through the raw-mode FIFOs.
 */
`timescale 1ns/1ps

module serial_link_data_link (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  serial_link_pkg::payload_t   payload_i,
  input  logic                        payload_valid_i,
  output logic                        payload_ready_o,
  output serial_link_pkg::payload_t   payload_o,
  output logic                        payload_valid_o,
  input  logic                        raw_mode_en_i,
  input  serial_link_pkg::lane_data_t raw_out_data_i,
  input  logic                        raw_out_push_i,
  output serial_link_pkg::raw_level_t raw_out_level_o,
  output logic                        raw_out_full_o,
  output serial_link_pkg::lane_data_t raw_in_data_o,
  output logic                        raw_in_valid_o,
  input  logic                        raw_in_pop_i,
  output serial_link_pkg::lane_data_t flit_o,
  output logic                        flit_valid_o,
  input  logic                        flit_ready_i,
  input  serial_link_pkg::lane_data_t flit_i,
  input  logic                        flit_valid_i
);
  import serial_link_pkg::*;

  logic                            raw_mode_q;
  logic                            mode_change;
  payload_t                        tx_word_q;
  logic                            tx_busy_q;
  logic [$clog2(FlitSplits)-1:0]   tx_cnt_q;
  payload_t                        rx_word_q;
  logic [$clog2(FlitSplits)-1:0]   rx_cnt_q;
  logic                            payload_hs;
  logic                            data_flit_hs;
  logic                            data_flit_in;

  lane_data_t tx_fifo_data;
  logic       tx_fifo_empty;
  logic       tx_fifo_pop;
  logic       rx_fifo_full;
  logic       raw_in_empty;

  assign mode_change  = raw_mode_en_i != raw_mode_q;
  // Stay closed for one cycle after leaving raw mode
  assign payload_ready_o = !raw_mode_en_i && !raw_mode_q && !tx_busy_q;
  assign payload_hs   = payload_valid_i && payload_ready_o;
  assign data_flit_hs = !raw_mode_en_i && flit_valid_o && flit_ready_i;
  assign data_flit_in = !raw_mode_en_i && flit_valid_i;

  //////////////////////////////
  // Flit counters
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      raw_mode_q      <= 1'b0;
      tx_busy_q       <= 1'b0;
      tx_cnt_q        <= '0;
      rx_cnt_q        <= '0;
      payload_valid_o <= 1'b0;
    end else begin
      raw_mode_q      <= raw_mode_en_i;
      payload_valid_o <= 1'b0;
      if (mode_change) begin
        tx_busy_q <= 1'b0;
        tx_cnt_q  <= '0;
        rx_cnt_q  <= '0;
      end else begin
        if (payload_hs) begin
          tx_busy_q <= 1'b1;
          tx_cnt_q  <= '0;
        end else if (data_flit_hs) begin
          tx_cnt_q <= tx_cnt_q + 1'b1;
          if (int'(tx_cnt_q) == FlitSplits - 1) begin
            tx_busy_q <= 1'b0;
          end
        end
        if (data_flit_in) begin
          rx_cnt_q <= rx_cnt_q + 1'b1;
          // Word complete after the last flit
          if (int'(rx_cnt_q) == FlitSplits - 1) begin
            payload_valid_o <= 1'b1;
          end
        end
      end
    end
  end

  // Split and reassembly shift registers, low flit first
  always_ff @(posedge clk_i) begin
    if (payload_hs) begin
      tx_word_q <= payload_i;
    end else if (data_flit_hs) begin
      tx_word_q <= tx_word_q >> NumLanes;
    end
    if (data_flit_in) begin
      rx_word_q <= {flit_i, rx_word_q[PayloadBits-1:NumLanes]};
    end
  end

  assign payload_o = rx_word_q;

  //////////////////////////////
  // Raw mode and flit mux
  //////////////////////////////

  assign tx_fifo_pop  = raw_mode_en_i && flit_ready_i && !tx_fifo_empty;
  assign flit_o       = raw_mode_en_i ? tx_fifo_data : tx_word_q[NumLanes-1:0];
  assign flit_valid_o = raw_mode_en_i ? !tx_fifo_empty : tx_busy_q;

  serial_link_fifo i_raw_out_fifo (
    .clk_i   ( clk_i                            ),
    .reset_i ( reset_i                          ),
    .push_i  ( raw_out_push_i && !raw_out_full_o ),
    .data_i  ( raw_out_data_i                   ),
    .pop_i   ( tx_fifo_pop                      ),
    .data_o  ( tx_fifo_data                     ),
    .empty_o ( tx_fifo_empty                    ),
    .full_o  ( raw_out_full_o                   ),
    .level_o ( raw_out_level_o                  )
  );

  // Received flits are dropped when this FIFO is full
  serial_link_fifo i_raw_in_fifo (
    .clk_i   ( clk_i                                         ),
    .reset_i ( reset_i                                       ),
    .push_i  ( raw_mode_en_i && flit_valid_i && !rx_fifo_full ),
    .data_i  ( flit_i                                        ),
    .pop_i   ( raw_in_pop_i                                  ),
    .data_o  ( raw_in_data_o                                 ),
    .empty_o ( raw_in_empty                                  ),
    .full_o  ( rx_fifo_full                                  ),
    .level_o (                                               )
  );

  assign raw_in_valid_o = !raw_in_empty;

endmodule

//--- hw/serial_link_phy_tx.sv
/*
 * Transmit physical layer. Holds one flit on the lanes and forwards
 * a clock period of twice the divider value for it.
 */
`timescale 1ns/1ps

module serial_link_phy_tx (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  serial_link_pkg::clk_div_t   clk_div_i,
  input  serial_link_pkg::lane_data_t flit_i,
  input  logic                        flit_valid_i,
  output logic                        flit_ready_o,
  output serial_link_pkg::lane_data_t ddr_o,
  output logic                        ddr_rcv_clk_o
);
  import serial_link_pkg::*;

  tx_state_e  state_q;
  clk_div_t   cnt_q;
  clk_div_t   half_period;
  lane_data_t ddr_q;
  logic       rcv_clk_q;
  logic       phase_done;

  // Divider values below the minimum are raised
  assign half_period = (clk_div_i < clk_div_t'(MinClkDiv)) ? clk_div_t'(MinClkDiv) : clk_div_i;
  assign phase_done  = cnt_q >= half_period - 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      rcv_clk_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (flit_valid_i) begin
            state_q <= LOW;
          end
        end
        LOW: begin
          cnt_q <= cnt_q + 1'b1;
          if (phase_done) begin
            state_q   <= HIGH;
            cnt_q     <= '0;
            rcv_clk_q <= 1'b1;
          end
        end
        HIGH: begin
          cnt_q <= cnt_q + 1'b1;
          if (phase_done) begin
            state_q   <= IDLE;
            cnt_q     <= '0;
            rcv_clk_q <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Lanes keep the last flit between transfers
  always_ff @(posedge clk_i) begin
    if (flit_valid_i && flit_ready_o) begin
      ddr_q <= flit_i;
    end
  end

  assign flit_ready_o  = (state_q == IDLE);
  assign ddr_o         = ddr_q;
  assign ddr_rcv_clk_o = rcv_clk_q;

  // A full forwarded clock period passes before the next flit is taken
  a_ready_idle_only : assert property (
    @(posedge clk_i) disable iff (reset_i)
    flit_valid_i && flit_ready_o |=> (!flit_ready_o) [*2*MinClkDiv]
  );

endmodule

//--- hw/serial_link_phy_rx.sv
/*
 * Receive physical layer. Synchronizes the forwarded clock and lanes,
 * and samples one flit on each rising edge of the forwarded clock.
 */
`timescale 1ns/1ps

module serial_link_phy_rx (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  serial_link_pkg::lane_data_t ddr_i,
  input  logic                        ddr_rcv_clk_i,
  output serial_link_pkg::lane_data_t flit_o,
  output logic                        flit_valid_o
);
  import serial_link_pkg::*;

  logic [1:0] clk_sync_q;
  logic       clk_prev_q;
  lane_data_t lane_sync1_q;
  lane_data_t lane_sync2_q;
  lane_data_t flit_q;
  logic       rise;

  // Two-flop synchronizer plus edge history
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      clk_sync_q   <= '0;
      clk_prev_q   <= 1'b0;
      flit_valid_o <= 1'b0;
    end else begin
      clk_sync_q   <= {clk_sync_q[0], ddr_rcv_clk_i};
      clk_prev_q   <= clk_sync_q[1];
      flit_valid_o <= rise;
    end
  end

  always_ff @(posedge clk_i) begin
    lane_sync1_q <= ddr_i;
    lane_sync2_q <= lane_sync1_q;
    if (rise) begin
      flit_q <= lane_sync2_q;
    end
  end

  assign rise   = clk_sync_q[1] && !clk_prev_q;
  assign flit_o = flit_q;

endmodule

//--- hw/serial_link.sv
/*
 * Top level of the single-channel serial link. Connects the register block,
 * the data link layer and the transmit and receive physical layers.
 */
`timescale 1ns/1ps

module serial_link (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  serial_link_pkg::reg_addr_t  reg_addr_i,
  input  serial_link_pkg::reg_data_t  reg_wdata_i,
  input  logic                        reg_wr_i,
  input  logic                        reg_rd_i,
  output serial_link_pkg::reg_data_t  reg_rdata_o,
  input  serial_link_pkg::payload_t   payload_i,
  input  logic                        payload_valid_i,
  output logic                        payload_ready_o,
  output serial_link_pkg::payload_t   payload_o,
  output logic                        payload_valid_o,
  input  serial_link_pkg::lane_data_t ddr_i,
  output serial_link_pkg::lane_data_t ddr_o,
  input  logic                        ddr_rcv_clk_i,
  output logic                        ddr_rcv_clk_o,
  input  logic [1:0]                  isolated_i,
  output logic [1:0]                  isolate_o,
  output logic                        clk_ena_o,
  output logic                        reset_no
);
  import serial_link_pkg::*;

  clk_div_t   clk_div;
  logic       raw_mode_en;
  lane_data_t raw_out_data;
  logic       raw_out_push;
  raw_level_t raw_out_level;
  logic       raw_out_full;
  lane_data_t raw_in_data;
  logic       raw_in_valid;
  logic       raw_in_pop;
  lane_data_t tx_flit;
  logic       tx_flit_valid;
  logic       tx_flit_ready;
  lane_data_t rx_flit;
  logic       rx_flit_valid;

  //////////////////////////////
  // Configuration registers
  //////////////////////////////

  serial_link_reg_top i_reg_top (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .reg_addr_i      ( reg_addr_i    ),
    .reg_wdata_i     ( reg_wdata_i   ),
    .reg_wr_i        ( reg_wr_i      ),
    .reg_rd_i        ( reg_rd_i      ),
    .reg_rdata_o     ( reg_rdata_o   ),
    .isolated_i      ( isolated_i    ),
    .raw_out_level_i ( raw_out_level ),
    .raw_out_full_i  ( raw_out_full  ),
    .raw_in_data_i   ( raw_in_data   ),
    .raw_in_valid_i  ( raw_in_valid  ),
    .clk_ena_o       ( clk_ena_o     ),
    .reset_no        ( reset_no      ),
    .isolate_o       ( isolate_o     ),
    .raw_mode_en_o   ( raw_mode_en   ),
    .clk_div_o       ( clk_div       ),
    .raw_out_data_o  ( raw_out_data  ),
    .raw_out_push_o  ( raw_out_push  ),
    .raw_in_pop_o    ( raw_in_pop    )
  );

  //////////////////////////////
  // Data link layer
  //////////////////////////////

  serial_link_data_link i_data_link (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .payload_i       ( payload_i       ),
    .payload_valid_i ( payload_valid_i ),
    .payload_ready_o ( payload_ready_o ),
    .payload_o       ( payload_o       ),
    .payload_valid_o ( payload_valid_o ),
    .raw_mode_en_i   ( raw_mode_en     ),
    .raw_out_data_i  ( raw_out_data    ),
    .raw_out_push_i  ( raw_out_push    ),
    .raw_out_level_o ( raw_out_level   ),
    .raw_out_full_o  ( raw_out_full    ),
    .raw_in_data_o   ( raw_in_data     ),
    .raw_in_valid_o  ( raw_in_valid    ),
    .raw_in_pop_i    ( raw_in_pop      ),
    .flit_o          ( tx_flit         ),
    .flit_valid_o    ( tx_flit_valid   ),
    .flit_ready_i    ( tx_flit_ready   ),
    .flit_i          ( rx_flit         ),
    .flit_valid_i    ( rx_flit_valid   )
  );

  //////////////////////////////
  // Physical layer
  //////////////////////////////

  serial_link_phy_tx i_phy_tx (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .clk_div_i     ( clk_div       ),
    .flit_i        ( tx_flit       ),
    .flit_valid_i  ( tx_flit_valid ),
    .flit_ready_o  ( tx_flit_ready ),
    .ddr_o         ( ddr_o         ),
    .ddr_rcv_clk_o ( ddr_rcv_clk_o )
  );

  serial_link_phy_rx i_phy_rx (
    .clk_i         ( clk_i         ),
    .reset_i       ( reset_i       ),
    .ddr_i         ( ddr_i         ),
    .ddr_rcv_clk_i ( ddr_rcv_clk_i ),
    .flit_o        ( rx_flit       ),
    .flit_valid_o  ( rx_flit_valid )
  );

endmodule

//--- testbench/tb_serial_link.sv
/*
 * Directed loopback testbench for the serial link. The lanes and the forwarded
 * clock are wired back into the receiver, and each test task checks one feature.
 */
`timescale 1ns/1ps

module tb_serial_link;
  import serial_link_pkg::*;

  localparam int TimeoutCycles = 20000;

  logic       clk_i;
  logic       reset_i;
  reg_addr_t  reg_addr_i;
  reg_data_t  reg_wdata_i;
  logic       reg_wr_i;
  logic       reg_rd_i;
  reg_data_t  reg_rdata_o;
  payload_t   payload_i;
  logic       payload_valid_i;
  logic       payload_ready_o;
  payload_t   payload_o;
  logic       payload_valid_o;
  lane_data_t ddr_lanes;
  logic       ddr_rcv_clk;
  logic [1:0] isolated_i;
  logic [1:0] isolate_o;
  logic       clk_ena_o;
  logic       reset_no;

  logic [31:0] lfsr_q;
  int          cycle_cnt;
  payload_t    exp_q[$];
  payload_t    rcv_q[$];

  serial_link serial_link_i (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .reg_addr_i      ( reg_addr_i      ),
    .reg_wdata_i     ( reg_wdata_i     ),
    .reg_wr_i        ( reg_wr_i        ),
    .reg_rd_i        ( reg_rd_i        ),
    .reg_rdata_o     ( reg_rdata_o     ),
    .payload_i       ( payload_i       ),
    .payload_valid_i ( payload_valid_i ),
    .payload_ready_o ( payload_ready_o ),
    .payload_o       ( payload_o       ),
    .payload_valid_o ( payload_valid_o ),
    .ddr_i           ( ddr_lanes       ),
    .ddr_o           ( ddr_lanes       ),
    .ddr_rcv_clk_i   ( ddr_rcv_clk     ),
    .ddr_rcv_clk_o   ( ddr_rcv_clk     ),
    .isolated_i      ( isolated_i      ),
    .isolate_o       ( isolate_o       ),
    .clk_ena_o       ( clk_ena_o       ),
    .reset_no        ( reset_no        )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  // Collect received words
  always @(negedge clk_i) begin
    if (!reset_i && payload_valid_o) begin
      rcv_q.push_back(payload_o);
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk_i);
    reg_addr_i  = addr;
    reg_wdata_i = data;
    reg_wr_i    = 1'b1;
    @(negedge clk_i);
    reg_wr_i    = 1'b0;
  endtask

  // Read data is sampled in the low phase, before the edge that pops
  task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
    @(negedge clk_i);
    reg_addr_i = addr;
    reg_rd_i   = 1'b1;
    #1;
    data = reg_rdata_o;
    @(negedge clk_i);
    reg_rd_i   = 1'b0;
  endtask

  // 32-bit Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic payload_t next_random_word();
    logic     fb;
    payload_t word;
    word = '0;
    for (int i = 0; i < PayloadBits; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      word   = {word[PayloadBits-2:0], fb};
    end
    return word;
  endfunction

  // Keeps valid high across words
  task automatic send_words(input int count);
    payload_t word;
    @(negedge clk_i);
    for (int i = 0; i < count; i++) begin
      word            = next_random_word();
      payload_i       = word;
      payload_valid_i = 1'b1;
      while (!payload_ready_o) begin
        @(negedge clk_i);
      end
      exp_q.push_back(word);
      @(negedge clk_i);
    end
    payload_valid_i = 1'b0;
  endtask

  task automatic compare_received_words();
    while (rcv_q.size() < exp_q.size()) begin
      @(negedge clk_i);
    end
    while (exp_q.size() > 0) begin
      check_value("payload_o", rcv_q.pop_front(), exp_q.pop_front());
    end
    check_value("extra payload_valid_o words", rcv_q.size(), 0);
  endtask

  task automatic measure_high_phase(output int cycles);
    cycles = 0;
    @(negedge clk_i);
    while (ddr_rcv_clk) begin
      @(negedge clk_i);
    end
    while (!ddr_rcv_clk) begin
      @(negedge clk_i);
    end
    while (ddr_rcv_clk) begin
      cycles++;
      @(negedge clk_i);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    reg_data_t data;
    reg_read(RegCtrl, data);
    check_value("RegCtrl", data, 32'h0000_0003);
    reg_read(RegClkDiv, data);
    check_value("RegClkDiv", data, 32'h0000_0004);
    check_value("clk_ena_o", clk_ena_o, 1);
    check_value("reset_no", reset_no, 1);
    check_value("isolate_o", isolate_o, 0);
    check_value("ddr_rcv_clk_o", ddr_rcv_clk, 0);
    check_value("payload_ready_o", payload_ready_o, 1);
    check_value("payload_valid_o", payload_valid_o, 0);
  endtask

  task automatic test_control_status();
    reg_data_t data;
    // Clock off, link in reset, both sides isolated
    reg_write(RegCtrl, 32'h0000_000C);
    check_value("clk_ena_o", clk_ena_o, 0);
    check_value("reset_no", reset_no, 0);
    check_value("isolate_o", isolate_o, 2'b11);
    reg_write(RegCtrl, 32'h0000_0005);
    check_value("clk_ena_o", clk_ena_o, 1);
    check_value("reset_no", reset_no, 0);
    check_value("isolate_o", isolate_o, 2'b01);
    reg_write(RegCtrl, 32'h0000_0003);
    check_value("reset_no", reset_no, 1);
    check_value("isolate_o", isolate_o, 2'b00);

    isolated_i = 2'b10;
    reg_read(RegStatus, data);
    check_value("RegStatus", data, 32'h0000_0002);
    isolated_i = 2'b01;
    reg_read(RegStatus, data);
    check_value("RegStatus", data, 32'h0000_0001);
    isolated_i = 2'b00;
  endtask

  task automatic test_divider_timing();
    int        div_values[3];
    int        cycles;
    int        expected;
    reg_data_t data;
    div_values = '{3, 6, 1};
    foreach (div_values[i]) begin
      reg_write(RegClkDiv, div_values[i]);
      reg_read(RegClkDiv, data);
      check_value("RegClkDiv", data, div_values[i]);
      expected = (div_values[i] < 2) ? 2 : div_values[i];
      send_words(1);
      measure_high_phase(cycles);
      check_value("ddr_rcv_clk_o high cycles", cycles, expected);
      compare_received_words();
    end
  endtask

  task automatic test_payload_loopback();
    reg_write(RegClkDiv, 4);
    send_words(12);
    compare_received_words();
  endtask

  task automatic test_raw_mode();
    logic [7:0] bytes[5];
    reg_data_t  data;
    bytes = '{8'hA5, 8'h3C, 8'h01, 8'hFE, 8'h5A};
    reg_write(RegCtrl, 32'h0000_0013);
    check_value("payload_ready_o", payload_ready_o, 0);
    foreach (bytes[i]) begin
      reg_write(RegRawOut, {24'h0, bytes[i]});
    end
    // Poll until each flit has come round the loop
    foreach (bytes[i]) begin
      data = '0;
      while (!data[8]) begin
        reg_read(RegRawIn, data);
      end
      check_value("RegRawIn", data, {23'h0, 1'b1, bytes[i]});
    end
    reg_read(RegRawIn, data);
    check_value("RegRawIn when empty", data, 0);
  endtask

  initial begin
    reset_i         = 1'b1;
    reg_addr_i      = '0;
    reg_wdata_i     = '0;
    reg_wr_i        = 1'b0;
    reg_rd_i        = 1'b0;
    payload_i       = '0;
    payload_valid_i = 1'b0;
    isolated_i      = 2'b00;
    lfsr_q          = 32'd23023;
    cycle_cnt       = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_reset_state();
    test_control_status();
    test_divider_timing();
    test_payload_loopback();
    test_raw_mode();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- files.f
hw/serial_link_pkg.sv
hw/serial_link_fifo.sv
hw/serial_link_reg_top.sv
hw/serial_link_data_link.sv
hw/serial_link_phy_tx.sv
hw/serial_link_phy_rx.sv
hw/serial_link.sv
testbench/tb_serial_link.sv

//--- Makefile
# Verilator flow for the serial link testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module tb_serial_link
	verilator --lint-only -f files.f --top-module serial_link

sim:
	verilator --binary --timing --assert -j 0 -f files.f \
		--top-module tb_serial_link -Mdir obj_dir -o Vtb_serial_link
	./obj_dir/Vtb_serial_link > sim.log 2>&1 || true
	cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
